/* design/i2s_pkg.sv */
package i2s_pkg;

    //////////////////////////////////////////////////
    // widths and register map
    //////////////////////////////////////////////////

    localparam int I2S_DATA_W = 32;                   // sample and APB data width
    localparam int APB_ADDR_W = 4;                    // APB byte address width

    localparam logic [APB_ADDR_W-1:0] I2S_REG_CTRL   = 4'h0;
    localparam logic [APB_ADDR_W-1:0] I2S_REG_CLKDIV = 4'h4;
    localparam logic [APB_ADDR_W-1:0] I2S_REG_DATA   = 4'h8;
    localparam logic [APB_ADDR_W-1:0] I2S_REG_STATUS = 4'hC;

    localparam int I2S_STAT_EMPTY_BIT    = 8;
    localparam int I2S_STAT_FULL_BIT     = 9;
    localparam int I2S_STAT_UNDERRUN_BIT = 10;        // sticky, write 1 to clear
    localparam int I2S_STAT_OVERFLOW_BIT = 11;        // sticky, write 1 to clear

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef enum logic {
        I2S_FMT_MONO32   = 1'b0,                      // one word per slot
        I2S_FMT_STEREO16 = 1'b1                       // one word per frame
    } i2s_fmt_e;

    typedef struct packed {
        logic        enable;
        i2s_fmt_e    fmt;
        logic [15:0] clkdiv;                          // sck half period in clk cycles
    } i2s_ctrl_t;

    typedef struct packed {
        logic [15:0] left;                            // upper half
        logic [15:0] right;                           // lower half
    } i2s_pair_t;

    // a FIFO word read either as one mono sample or as a stereo pair
    typedef union packed {
        logic [I2S_DATA_W-1:0] word;
        i2s_pair_t             pair;
    } i2s_sample_u;

    typedef struct packed {
        logic        valid;                           // one-cycle write strobe
        i2s_sample_u sample;
    } i2s_push_t;

    typedef struct packed {
        logic        valid;                           // low when the pop hit an empty FIFO
        i2s_sample_u sample;
    } i2s_pop_t;

endpackage

/* design/i2s_sck_gen.sv */
`timescale 1ns/1ps

module i2s_sck_gen
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [15:0] clkdiv,
    output logic        sck,
    output logic        sck_fall,
    output logic        sck_rise
);

    logic [15:0] cnt;                             // cycles left before next toggle
    logic [15:0] reload;
    logic        toggle;

    // values under 2 run at the fastest legal rate
    assign reload = (clkdiv < 16'd2) ? 16'd1 : clkdiv - 16'd1;

    // strobes mark the cycle whose closing edge moves sck
    assign toggle   = enable && (cnt == 16'd0);
    assign sck_rise = toggle && !sck;
    assign sck_fall = toggle && sck;

    //////////////////////////////////////////////////
    // divider
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt <= 16'd0;
            sck <= 1'b0;
        end
        else if (!enable)
        begin
            cnt <= 16'd0;                         // park low, first toggle is a rise
            sck <= 1'b0;
        end
        else if (toggle)
        begin
            cnt <= reload;
            sck <= ~sck;
        end
        else
        begin
            cnt <= cnt - 16'd1;
        end
    end

endmodule

/* design/i2s_sample_fifo.sv */
`timescale 1ns/1ps

module i2s_sample_fifo
    import i2s_pkg::*;
#(
    parameter int FIFO_AW = 3
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  i2s_push_t        push,
    input  logic             pop_req,
    output i2s_pop_t         pop,
    output logic [FIFO_AW:0] level,
    output logic             full,
    output logic             empty
);

    localparam int DEPTH = 2 ** FIFO_AW;

    i2s_sample_u         mem [DEPTH];
    logic [FIFO_AW:0]    wr_ptr;                  // extra msb tells full from empty
    logic [FIFO_AW:0]    rd_ptr;
    logic                do_pop;
    logic                pop_valid_q;
    i2s_sample_u         pop_data_q;

    assign empty  = (wr_ptr == rd_ptr);
    assign full   = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                    (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign level  = wr_ptr - rd_ptr;
    assign do_pop = pop_req && !empty;

    //////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            pop_valid_q <= 1'b0;
        end
        else
        begin
            if (push.valid)
                wr_ptr <= wr_ptr + 1'b1;          // never full here, regs drop it
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            pop_valid_q <= do_pop;
        end
    end

    //////////////////////////////////////////////////
    // storage and read data
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (push.valid)
            mem[wr_ptr[FIFO_AW-1:0]] <= push.sample;
    end

    always_ff @(posedge clk)
    begin
        if (do_pop)
            pop_data_q <= mem[rd_ptr[FIFO_AW-1:0]];
    end

    assign pop.valid  = pop_valid_q;
    assign pop.sample = pop_data_q;

endmodule

/* design/i2s_apb_regs.sv */
`timescale 1ns/1ps

module i2s_apb_regs
    import i2s_pkg::*;
#(
    parameter int FIFO_AW = 3
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [I2S_DATA_W-1:0] pwdata,
    output logic [I2S_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output i2s_ctrl_t             ctrl,
    output i2s_push_t             push,
    input  logic [FIFO_AW:0]      fifo_level,
    input  logic                  fifo_full,
    input  logic                  fifo_empty,
    input  logic                  underrun_evt
);

    logic                  access;                // APB access phase
    logic                  wr_en;
    logic                  rd_en;
    logic                  addr_hit;              // one of the four registers
    logic                  data_wr;
    logic                  push_valid_q;
    logic [I2S_DATA_W-1:0] push_data_q;
    logic                  underrun_flag;
    logic                  overflow_flag;
    logic                  clr_underrun;
    logic                  clr_overflow;
    logic [I2S_DATA_W-1:0] status_word;

    assign access   = psel && penable;
    assign wr_en    = access && pwrite;
    assign rd_en    = access && !pwrite;
    assign addr_hit = (paddr == I2S_REG_CTRL) || (paddr == I2S_REG_CLKDIV) ||
                      (paddr == I2S_REG_DATA) || (paddr == I2S_REG_STATUS);
    assign data_wr  = wr_en && (paddr == I2S_REG_DATA);

    assign clr_underrun = wr_en && (paddr == I2S_REG_STATUS) && pwdata[I2S_STAT_UNDERRUN_BIT];
    assign clr_overflow = wr_en && (paddr == I2S_REG_STATUS) && pwdata[I2S_STAT_OVERFLOW_BIT];

    assign pready  = 1'b1;                        // no wait states
    assign pslverr = access && (!addr_hit || (rd_en && paddr == I2S_REG_DATA));

    //////////////////////////////////////////////////
    // control registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl.enable <= 1'b0;
            ctrl.fmt    <= I2S_FMT_MONO32;
            ctrl.clkdiv <= 16'd2;
        end
        else if (wr_en && paddr == I2S_REG_CTRL)
        begin
            ctrl.enable <= pwdata[0];
            ctrl.fmt    <= i2s_fmt_e'(pwdata[1]);
        end
        else if (wr_en && paddr == I2S_REG_CLKDIV)
        begin
            ctrl.clkdiv <= pwdata[15:0];
        end
    end

    //////////////////////////////////////////////////
    // FIFO push and sticky flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            push_valid_q  <= 1'b0;
            underrun_flag <= 1'b0;
            overflow_flag <= 1'b0;
        end
        else
        begin
            push_valid_q  <= data_wr && !fifo_full;                       // drop when full
            underrun_flag <= (underrun_flag && !clr_underrun) || underrun_evt;
            overflow_flag <= (overflow_flag && !clr_overflow) || (data_wr && fifo_full);
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_wr)
            push_data_q <= pwdata;
    end

    assign push.valid       = push_valid_q;
    assign push.sample.word = push_data_q;

    // read side
    always_comb
    begin
        status_word = '0;
        status_word[7:0] = 8'(fifo_level);
        status_word[I2S_STAT_EMPTY_BIT]    = fifo_empty;
        status_word[I2S_STAT_FULL_BIT]     = fifo_full;
        status_word[I2S_STAT_UNDERRUN_BIT] = underrun_flag;
        status_word[I2S_STAT_OVERFLOW_BIT] = overflow_flag;
    end

    always_comb
    begin
        prdata = '0;
        if (rd_en)
        begin
            case (paddr)
                I2S_REG_CTRL:   prdata = {30'b0, ctrl.fmt, ctrl.enable};
                I2S_REG_CLKDIV: prdata = {16'b0, ctrl.clkdiv};
                I2S_REG_STATUS: prdata = status_word;
                default:        prdata = '0;                              // DATA is write only
            endcase
        end
    end

endmodule

/* design/i2s_serializer.sv */
`timescale 1ns/1ps

module i2s_serializer
    import i2s_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable,
    input  i2s_fmt_e fmt,
    input  logic     sck_fall,
    input  i2s_pop_t pop,
    output logic     pop_req,
    output logic     ws,
    output logic     sd,
    output logic     underrun_evt
);

    logic [5:0]            pos;                   // frame position of the next bit on sd
    logic [5:0]            pos_nxt;
    logic [I2S_DATA_W-1:0] shreg;                 // bits of the slot not yet sent
    logic [15:0]           right_hold;            // stereo16 right half
    logic                  pop_wait;              // FIFO answer is on pop this cycle
    logic                  slot_end;
    logic                  pop_point;
    logic                  stereo;

    assign stereo   = (fmt == I2S_FMT_STEREO16);
    assign pos_nxt  = pos + 6'd1;
    assign slot_end = (pos[4:0] == 5'd31);        // last bit of left or right slot

    // stereo16 pops only ahead of the left slot
    assign pop_point = slot_end && (!stereo || pos[5]);

    //////////////////////////////////////////////////
    // frame timing and shift register
    //////////////////////////////////////////////////

    // pos starts at 63 so the first sck fall acts as the
    // last bit of an empty frame and fetches the first word
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pos          <= 6'd63;
            ws           <= 1'b0;
            sd           <= 1'b0;
            pop_req      <= 1'b0;
            pop_wait     <= 1'b0;
            underrun_evt <= 1'b0;
            shreg        <= '0;
            right_hold   <= '0;
        end
        else if (!enable)
        begin
            pos          <= 6'd63;
            ws           <= 1'b0;
            sd           <= 1'b0;
            pop_req      <= 1'b0;
            pop_wait     <= 1'b0;
            underrun_evt <= 1'b0;
            shreg        <= '0;
            right_hold   <= '0;
        end
        else
        begin
            pop_req      <= sck_fall && pop_point;
            pop_wait     <= pop_req;
            underrun_evt <= pop_wait && !pop.valid;

            if (sck_fall)
            begin
                pos <= pos_nxt;
                ws  <= pos_nxt[5];                // leads the slot by one bit
                sd  <= shreg[I2S_DATA_W-1];
                if (stereo && slot_end && !pos[5])
                    shreg <= {right_hold, 16'h0000};            // right half for the next slot
                else
                    shreg <= {shreg[I2S_DATA_W-2:0], 1'b0};
            end
            else if (pop_wait)
            begin
                // falls are 2*clkdiv apart, the load lands between them
                if (!pop.valid)
                begin
                    shreg      <= '0;             // underrun sends silence
                    right_hold <= '0;
                end
                else if (stereo)
                begin
                    shreg      <= {pop.sample.pair.left, 16'h0000};
                    right_hold <= pop.sample.pair.right;
                end
                else
                begin
                    shreg <= pop.sample.word;
                end
            end
        end
    end

endmodule

/* design/i2s_tx_top.sv */
`timescale 1ns/1ps

module i2s_tx_top
    import i2s_pkg::*;
#(
    parameter int FIFO_AW = 3
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [I2S_DATA_W-1:0] pwdata,
    output logic [I2S_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  sck,
    output logic                  ws,
    output logic                  sd
);

    i2s_ctrl_t        ctrl;
    i2s_push_t        push;
    i2s_pop_t         pop;
    logic             pop_req;
    logic [FIFO_AW:0] fifo_level;
    logic             fifo_full;
    logic             fifo_empty;
    logic             underrun_evt;
    logic             sck_fall;

    //////////////////////////////////////////////////
    // register, FIFO and serializer stages
    //////////////////////////////////////////////////

    i2s_apb_regs #(.FIFO_AW(FIFO_AW)) u_i2s_apb_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .ctrl(ctrl), .push(push),
        .fifo_level(fifo_level), .fifo_full(fifo_full), .fifo_empty(fifo_empty),
        .underrun_evt(underrun_evt)
    );

    i2s_sample_fifo #(.FIFO_AW(FIFO_AW)) u_i2s_sample_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(push), .pop_req(pop_req), .pop(pop),
        .level(fifo_level), .full(fifo_full), .empty(fifo_empty)
    );

    i2s_sck_gen u_i2s_sck_gen (
        .clk(clk), .rst_n(rst_n),
        .enable(ctrl.enable), .clkdiv(ctrl.clkdiv),
        .sck(sck), .sck_fall(sck_fall),
        .sck_rise()                               // serializer works on falls only
    );

    i2s_serializer u_i2s_serializer (
        .clk(clk), .rst_n(rst_n),
        .enable(ctrl.enable), .fmt(ctrl.fmt), .sck_fall(sck_fall),
        .pop(pop), .pop_req(pop_req),
        .ws(ws), .sd(sd), .underrun_evt(underrun_evt)
    );

endmodule

/* tests/i2s_tx_properties.sv */
`timescale 1ns/1ps

module i2s_tx_properties
(
    input logic clk,
    input logic rst_n,
    input logic pready,
    input logic enable,
    input logic sck,
    input logic ws,
    input logic sd
);

    int fail_cnt;                                 // assertion failures so far

    initial
    begin
        fail_cnt = 0;
    end

    //////////////////////////////////////////////////
    // APB and I2S line checks
    //////////////////////////////////////////////////

    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else
        begin
            $error("pready went low");
            fail_cnt++;
        end

    // ws and sd only move on the edge that drops sck
    ws_on_fall: assert property (@(posedge clk) disable iff (!rst_n || !enable)
        $changed(ws) |-> $fell(sck))
        else
        begin
            $error("ws changed without a falling sck");
            fail_cnt++;
        end

    sd_on_fall: assert property (@(posedge clk) disable iff (!rst_n || !enable)
        $changed(sd) |-> $fell(sck))
        else
        begin
            $error("sd changed without a falling sck");
            fail_cnt++;
        end

    sck_parked: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> !sck)                         // divider held while off
        else
        begin
            $error("sck high while the transmitter is disabled");
            fail_cnt++;
        end

endmodule

bind i2s_tx_top i2s_tx_properties u_i2s_tx_properties (
    .clk(clk), .rst_n(rst_n), .pready(pready), .enable(ctrl.enable),
    .sck(sck), .ws(ws), .sd(sd)
);

/* tests/i2s_tx_tb.sv */
`timescale 1ns/1ps

module i2s_tx_tb
    import i2s_pkg::*;
();

    localparam int CLK_PERIOD = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [I2S_DATA_W-1:0] pwdata;
    logic [I2S_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  sck;
    logic                  ws;
    logic                  sd;

    i2s_sample_u exp_q [$];                       // slots expected, left first
    i2s_sample_u slot_q [$];                      // slots seen on sd
    logic        ch_q [$];                        // ws level of each captured slot
    logic        capturing;
    logic        started;                         // an sck fall has been seen
    logic        in_slot;
    logic        prev_ws;
    logic        slot_ch;
    logic [31:0] shift;
    int          bit_cnt;
    time         rise_t [2];
    int          tests;
    int          failed;
    int          errors;
    int          test_errors;
    logic        aborted;

    i2s_tx_top u_i2s_tx_top (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .sck(sck), .ws(ws), .sd(sd)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // I2S capture
    //////////////////////////////////////////////////

    always @(negedge sck)
    begin
        if (capturing)
            started = 1'b1;
    end

    // the bit sampled with a new ws level still closes the old slot
    always @(posedge sck)
    begin
        if (capturing && started)
        begin
            rise_t[0] = rise_t[1];
            rise_t[1] = $time;
            if (in_slot)
            begin
                shift = {shift[30:0], sd};
                bit_cnt++;
                if (bit_cnt == 32)
                begin
                    slot_q.push_back(i2s_sample_u'(shift));
                    ch_q.push_back(slot_ch);
                    in_slot = 1'b0;
                end
            end
            if (ws != prev_ws)
            begin
                in_slot = 1'b1;                   // MSB comes on the next rise
                bit_cnt = 0;
                slot_ch = ws;
                prev_ws = ws;
            end
        end
    end

    //////////////////////////////////////////////////
    // compare tasks and bus driver
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input i2s_sample_u exp_v,
                              input i2s_sample_u act_v);
        if (act_v !== exp_v)
        begin
            $display("Error at %0d ns: %s expected %08h, got %08h",
                     $time, name, exp_v.word, act_v.word);
            test_errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("Error at %0d ns: %s expected %08h, got %08h", $time, name, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;                           // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #8;
        rdata = prdata;                           // mid access phase
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_slots(input int n);
        int cycles;
        cycles = 0;
        while (slot_q.size() < n && cycles < 1000 * (n + 1))
        begin
            @(posedge clk);
            cycles++;
        end
        if (slot_q.size() < n)
        begin
            $display("Timeout: only %0d of %0d I2S slots arrived", slot_q.size(), n);
            test_errors++;
            aborted = 1'b1;
        end
    endtask

    // enable in the given format, capture n slots, then disable
    task automatic run_frames(input int n, input logic fmt, input int period);
        logic [31:0] rdata;
        logic        err;
        slot_q.delete();
        ch_q.delete();
        prev_ws   = 1'b1;                         // as if a right slot came before
        started   = 1'b0;
        in_slot   = 1'b0;
        bit_cnt   = 0;
        rise_t[0] = 0;
        rise_t[1] = 0;
        capturing = 1'b1;
        apb_transfer(1'b1, I2S_REG_CTRL, {30'b0, fmt, 1'b1}, rdata, err);
        wait_slots(n);
        capturing = 1'b0;
        apb_transfer(1'b1, I2S_REG_CTRL, {30'b0, fmt, 1'b0}, rdata, err);
        if (!aborted)
        begin
            check_reg("expected slot count", 32'(n), 32'(exp_q.size()));
            for (int i = 0; i < n && i < exp_q.size(); i++)
            begin
                check_word($sformatf("slot %0d", i), exp_q[i], slot_q[i]);
                check_flag($sformatf("ws of slot %0d", i), 1'(i % 2), ch_q[i]);
            end
            if (period != 0)
                check_reg("sck period", 32'(period), 32'((rise_t[1] - rise_t[0]) / CLK_PERIOD));
        end
        exp_q.delete();
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] expv;
        logic [31:0] rdata;
        logic        err;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        capturing = 1'b0;
        started   = 1'b0;
        in_slot   = 1'b0;
        prev_ws   = 1'b1;
        slot_ch   = 1'b0;
        shift     = '0;
        bit_cnt   = 0;
        tests     = 0;
        failed    = 0;
        errors    = 0;
        aborted   = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        fd = $fopen("tests/i2s_tx_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test file tests/i2s_tx_tests.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            if ($sscanf(line, "%s %h %h %h", op, arg, data, expv) != 4)
                continue;
            test_errors = 0;
            if (op == "W")
            begin
                apb_transfer(1'b1, arg[APB_ADDR_W-1:0], data, rdata, err);
                check_flag("pslverr", expv[0], err);
            end
            else if (op == "R")
            begin
                apb_transfer(1'b0, arg[APB_ADDR_W-1:0], 32'h0, rdata, err);
                check_flag("pslverr", 1'b0, err);
                check_reg($sformatf("prdata at %h", arg[APB_ADDR_W-1:0]), expv, rdata & data);
            end
            else if (op == "FILL")
            begin
                for (int i = 0; i < int'(arg); i++)
                begin
                    apb_transfer(1'b1, I2S_REG_DATA, data + 32'(i), rdata, err);
                    check_flag("pslverr", 1'b0, err);
                    if (i < int'(expv))
                        exp_q.push_back(i2s_sample_u'(data + 32'(i)));   // kept by the FIFO
                end
            end
            else if (op == "SEND")
            begin
                if (arg != 0)
                    apb_transfer(1'b1, I2S_REG_DATA, data, rdata, err);
                exp_q.push_back(i2s_sample_u'(expv));
            end
            else if (op == "UNDER")
            begin
                repeat (arg) exp_q.push_back(i2s_sample_u'(32'h0));          // silent slots
            end
            else if (op == "FMT")
            begin
                run_frames(int'(arg), data[0], int'(expv));
            end
            else
            begin
                $display("Unknown operation %s in the test file", op);
                test_errors++;
            end
            tests++;
            errors += test_errors;
            if (test_errors != 0)
                failed++;
            $display("test %0d %s %0h: %s", tests, op, arg, (test_errors == 0) ? "ok" : "FAIL");
        end
        if (fd != 0)
            $fclose(fd);

        if (u_i2s_tx_top.u_i2s_tx_properties.fail_cnt != 0)
        begin
            $display("The bound assertions failed %0d times",
                     u_i2s_tx_top.u_i2s_tx_properties.fail_cnt);
            errors += u_i2s_tx_top.u_i2s_tx_properties.fail_cnt;
        end

        $display("%0d tests run, %0d failing, %0d errors", tests, failed, errors);
        if (errors == 0 && !aborted)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* tests/i2s_tx_tests.txt */
# op  addr/count  data  expected, all numbers hex
# W write (expected pslverr), R read (data is a mask), FILL count words data+i (expected kept)
# SEND count writes of data (expected slot), UNDER count silent slots, FMT slots fmt sck period
R     C  FFF       100
W     0  2         0
R     0  3         2
W     4  1234      0
R     4  FFFF      1234
W     4  2         0
W     2  0         1
W     0  0         0
SEND  1  FFFFFFFF  FFFFFFFF
SEND  1  AAAAAAAA  AAAAAAAA
SEND  1  FFFF0000  FFFF0000
SEND  1  0000FFFF  0000FFFF
FMT   4  0         4
SEND  1  1234ABCD  12340000
SEND  0  0         ABCD0000
FMT   2  1         4
W     C  C00       0
UNDER 2  0         0
FMT   2  0         4
R     C  400       400
W     C  400       0
R     C  400       0
FILL  9  11223340  8
R     C  FFF       A08
UNDER 1  0         0
FMT   9  0         4
W     4  5         0
R     4  FFFF      5
UNDER 2  0         0
FMT   2  0         A

/* project.f */
design/i2s_pkg.sv
design/i2s_sck_gen.sv
design/i2s_sample_fifo.sv
design/i2s_apb_regs.sv
design/i2s_serializer.sv
design/i2s_tx_top.sv
tests/i2s_tx_properties.sv
tests/i2s_tx_tb.sv
